// ==== src/s1c88_bus_pkg.sv ====
package s1c88_bus_pkg;

    // 24-bit external address, page byte on top
    typedef logic [23:0] addr_t;

    // one byte on the data bus
    typedef logic [7:0] data_t;

    // bus status pins, encoded as on the real part
    typedef enum logic [1:0]
    {
        bus_idle      = 2'd0,
        bus_mem_write = 2'd2,
        bus_mem_read  = 2'd3
    } bus_status_e;

    // one bus cycle request, held until done
    typedef struct packed
    {
        logic  valid;
        logic  write;
        addr_t addr;
        data_t wdata;
    } bus_req_t;

    // done pulses for one clock, rdata valid with it on reads
    typedef struct packed
    {
        logic  done;
        data_t rdata;
    } bus_rsp_t;

endpackage

// ==== src/s1c88_isa_pkg.sv ====
package s1c88_isa_pkg;

    typedef logic [15:0] code_addr_t;
    typedef logic [7:0]  opcode_t;
    typedef logic [9:0]  ext_opcode_t;
    typedef logic [8:0]  uaddr_t;
    typedef logic [3:0]  upc_t;

    // prefix bytes that pull in an extension byte
    localparam opcode_t OP_EXT_CE   = 8'hCE;
    localparam opcode_t OP_EXT_CF   = 8'hCF;
    localparam opcode_t OP_EXT_BASE = 8'hCD;

    // extended opcodes with a table entry
    localparam ext_opcode_t XOP_LD_A_MEM   = 10'h044;
    localparam ext_opcode_t XOP_LD_BR_IMM  = 10'h0B4;
    localparam ext_opcode_t XOP_LD_MEM_IMM = 10'h0DD;
    localparam ext_opcode_t XOP_LD_EP_IMM  = 10'h1C5;

    // microprogram entry points
    localparam uaddr_t UA_NOP        = 9'd0;
    localparam uaddr_t UA_LD_A_MEM   = 9'd1;
    localparam uaddr_t UA_LD_MEM_IMM = 9'd2;
    localparam uaddr_t UA_LD_BR_IMM  = 9'd3;
    localparam uaddr_t UA_LD_EP_IMM  = 9'd4;

    typedef struct packed
    {
        opcode_t     opcode;
        opcode_t     opext;
        logic [15:0] imm;
    } instr_t;

    typedef struct packed
    {
        logic   need_opext;
        logic   need_imm;
        // set when a second immediate byte follows
        logic   imm_size;
        uaddr_t entry;
    } decode_t;

    typedef enum logic { kind_misc, kind_bus } micro_kind_e;

    typedef enum logic [2:0]
    {
        mov_none, mov_imm, mov_imm_low, mov_imm_high, mov_a, mov_br, mov_ep
    } micro_mov_e;

    typedef struct packed
    {
        micro_kind_e kind;
        logic        write;
        micro_mov_e  dst;
        micro_mov_e  src;
        logic        last;
    } micro_op_t;

    typedef enum logic [2:0]
    {
        st_vec_low, st_vec_high, st_opcode, st_opext, st_imm_low, st_imm_high, st_execute
    } fetch_state_e;

endpackage

// ==== src/s1c88_decode.sv ====
`timescale 1ns/1ps

module s1c88_decode
(
    input  s1c88_isa_pkg::opcode_t opcode,
    input  s1c88_isa_pkg::opcode_t opext,
    output s1c88_isa_pkg::decode_t dec
);
    import s1c88_isa_pkg::*;

    logic        need_opext;
    logic [1:0]  ext_page;
    ext_opcode_t ext_opcode;

    assign need_opext = (opcode == OP_EXT_CE) || (opcode == OP_EXT_CF);

    // CE gives page 1, CF page 2; the low two bits are enough
    assign ext_page   = opcode[1:0] - OP_EXT_BASE[1:0];
    assign ext_opcode = need_opext ? {ext_page, opext} : {2'b00, opcode};

    // translation table, anything unknown lands on the nop entry
    always_comb
    begin
        dec = '0;
        dec.need_opext = need_opext;
        dec.entry = UA_NOP;
        case (ext_opcode)
            XOP_LD_A_MEM:
            begin
                dec.need_imm = 1'b1;
                dec.entry = UA_LD_A_MEM;
            end
            XOP_LD_BR_IMM:
            begin
                dec.need_imm = 1'b1;
                dec.entry = UA_LD_BR_IMM;
            end
            XOP_LD_MEM_IMM:
            begin
                // ll then nn
                dec.need_imm = 1'b1;
                dec.imm_size = 1'b1;
                dec.entry = UA_LD_MEM_IMM;
            end
            XOP_LD_EP_IMM:
            begin
                dec.need_imm = 1'b1;
                dec.entry = UA_LD_EP_IMM;
            end
            default:
            begin
                dec.entry = UA_NOP;
            end
        endcase
    end

endmodule

// ==== src/s1c88_fetch.sv ====
`timescale 1ns/1ps

module s1c88_fetch
#(
    parameter s1c88_bus_pkg::addr_t VECTOR_ADDR = '0
)
(
    input  logic                    clk,
    input  logic                    reset,
    input  s1c88_bus_pkg::bus_rsp_t bus_rsp,
    output s1c88_bus_pkg::bus_req_t fetch_req,
    output logic                    opcode_fetch,
    output s1c88_isa_pkg::instr_t   instr,
    output logic                    start,
    output s1c88_isa_pkg::decode_t  entry,
    input  logic                    finished
);
    import s1c88_bus_pkg::*;
    import s1c88_isa_pkg::*;

    localparam addr_t VECTOR_HIGH_ADDR = VECTOR_ADDR + addr_t'(1);

    fetch_state_e state;
    fetch_state_e state_next;
    code_addr_t   pc;
    opcode_t      dec_opcode;
    opcode_t      dec_opext;
    decode_t      dec;

    // decode the byte arriving on the bus while it is being fetched
    assign dec_opcode = (state == st_opcode) ? bus_rsp.rdata : instr.opcode;
    assign dec_opext  = (state == st_opext) ? bus_rsp.rdata : instr.opext;

    s1c88_decode decode_inst
    (
        .opcode (dec_opcode),
        .opext  (dec_opext),
        .dec    (dec)
    );

    assign entry        = dec;
    assign opcode_fetch = (state == st_opcode);

    always_comb
    begin
        fetch_req = '0;
        fetch_req.valid = (state != st_execute);
        case (state)
            st_vec_low:  fetch_req.addr = VECTOR_ADDR;
            st_vec_high: fetch_req.addr = VECTOR_HIGH_ADDR;
            // code always lives in page 00
            default:     fetch_req.addr = {8'h00, pc};
        endcase
    end

    always_comb
    begin
        state_next = state;
        case (state)
            st_vec_low:  if (bus_rsp.done) state_next = st_vec_high;
            st_vec_high: if (bus_rsp.done) state_next = st_opcode;
            st_opcode:
                if (bus_rsp.done)
                    state_next = dec.need_opext ? st_opext :
                                 dec.need_imm   ? st_imm_low : st_execute;
            st_opext:
                if (bus_rsp.done)
                    state_next = dec.need_imm ? st_imm_low : st_execute;
            st_imm_low:
                if (bus_rsp.done)
                    state_next = dec.imm_size ? st_imm_high : st_execute;
            st_imm_high: if (bus_rsp.done) state_next = st_execute;
            default:     if (finished) state_next = st_opcode;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= st_vec_low;
            pc    <= '0;
            start <= 1'b0;
        end
        else
        begin
            state <= state_next;
            start <= (state_next == st_execute) && (state != st_execute);
            if (bus_rsp.done && state == st_vec_low)
                pc[7:0] <= bus_rsp.rdata;
            else if (bus_rsp.done && state == st_vec_high)
                pc[15:8] <= bus_rsp.rdata;
            else if (bus_rsp.done && state != st_execute)
                pc <= pc + code_addr_t'(1);
        end
    end

    // instruction bytes
    always_ff @(posedge clk)
    begin
        if (bus_rsp.done)
        begin
            case (state)
                st_opcode:   instr.opcode    <= bus_rsp.rdata;
                st_opext:    instr.opext     <= bus_rsp.rdata;
                st_imm_low:  instr.imm[7:0]  <= bus_rsp.rdata;
                st_imm_high: instr.imm[15:8] <= bus_rsp.rdata;
                default:
                begin
                end
            endcase
        end
    end

    // the sequencer may only be kicked once all bytes are in
    start_in_execute: assert property (@(posedge clk) disable iff (reset)
        start |-> state == st_execute);

endmodule

// ==== src/s1c88_microseq.sv ====
`timescale 1ns/1ps

module s1c88_microseq
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  s1c88_isa_pkg::decode_t  entry,
    input  s1c88_isa_pkg::instr_t   instr,
    input  s1c88_bus_pkg::bus_rsp_t bus_rsp,
    output s1c88_bus_pkg::bus_req_t exec_req,
    output logic                    finished
);
    import s1c88_bus_pkg::*;
    import s1c88_isa_pkg::*;

    logic        running;
    uaddr_t      base;
    upc_t        upc;
    micro_op_t   cur;
    logic        step_done;
    logic [15:0] src_val;
    logic [15:0] dst_val;
    data_t       wr_val;
    logic [15:0] ba;
    data_t       ep;
    data_t       br;

    // micro ROM with a single step per entry
    function automatic micro_op_t rom_lookup(input uaddr_t ua);
        case (ua)
            UA_LD_A_MEM:   return '{kind_bus, 1'b0, mov_a, mov_imm_low, 1'b1};
            UA_LD_MEM_IMM: return '{kind_bus, 1'b1, mov_imm_low, mov_imm_high, 1'b1};
            UA_LD_BR_IMM:  return '{kind_misc, 1'b0, mov_br, mov_imm, 1'b1};
            UA_LD_EP_IMM:  return '{kind_misc, 1'b0, mov_ep, mov_imm, 1'b1};
            default:       return '{kind_misc, 1'b0, mov_none, mov_none, 1'b1};
        endcase
    endfunction

    function automatic logic [15:0] mov_value(input micro_mov_e sel);
        case (sel)
            mov_imm:      return instr.imm;
            mov_imm_low:  return {8'h00, instr.imm[7:0]};
            mov_imm_high: return {8'h00, instr.imm[15:8]};
            mov_a:        return {8'h00, ba[7:0]};
            mov_br:       return {8'h00, br};
            mov_ep:       return {8'h00, ep};
            default:      return 16'h0000;
        endcase
    endfunction

    // operand values also follow instr and the registers
    always_comb
    begin
        cur     = rom_lookup(base + {5'd0, upc});
        src_val = mov_value(cur.src);
        dst_val = mov_value(cur.dst);
    end

    // writes take their address from dst, reads from src
    always_comb
    begin
        exec_req = '0;
        exec_req.valid = running && (cur.kind == kind_bus);
        exec_req.write = cur.write;
        exec_req.addr  = {ep, br, cur.write ? dst_val[7:0] : src_val[7:0]};
        exec_req.wdata = src_val[7:0];
    end

    assign step_done = running && ((cur.kind == kind_misc) || bus_rsp.done);
    assign finished  = step_done && cur.last;
    assign wr_val    = (cur.kind == kind_bus) ? bus_rsp.rdata : src_val[7:0];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            running <= 1'b0;
            base    <= '0;
            upc     <= '0;
            ba      <= '0;
            ep      <= '0;
            br      <= '0;
        end
        else if (start)
        begin
            running <= 1'b1;
            base    <= entry.entry;
            upc     <= '0;
        end
        else if (step_done)
        begin
            running <= !cur.last;
            upc     <= cur.last ? upc_t'(0) : upc + upc_t'(1);
            if (!(cur.kind == kind_bus && cur.write))
            begin
                case (cur.dst)
                    mov_a:  ba <= {ba[15:8], wr_val};
                    mov_br: br <= wr_val;
                    mov_ep: ep <= wr_val;
                    default:
                    begin
                    end
                endcase
            end
        end
    end

    upc_in_range: assert property (@(posedge clk) disable iff (reset)
        upc < upc_t'(15));

endmodule

// ==== src/s1c88_bus_unit.sv ====
`timescale 1ns/1ps

module s1c88_bus_unit
(
    input  logic                       clk,
    input  logic                       reset,
    input  s1c88_bus_pkg::bus_req_t    fetch_req,
    input  s1c88_bus_pkg::bus_req_t    exec_req,
    input  logic                       opcode_fetch,
    output s1c88_bus_pkg::bus_rsp_t    bus_rsp,
    input  s1c88_bus_pkg::data_t       data_in,
    output s1c88_bus_pkg::data_t       data_out,
    output s1c88_bus_pkg::addr_t       address_out,
    output s1c88_bus_pkg::bus_status_e bus_status,
    output logic                       read,
    output logic                       write,
    output logic                       sync
);
    import s1c88_bus_pkg::*;

    typedef enum logic [1:0] { ph_idle, ph_addr, ph_strobe } phase_e;

    phase_e   phase;
    bus_req_t sel_req;
    logic     done_q;
    data_t    rdata_q;

    // only one requester is active at any time
    assign sel_req = exec_req.valid ? exec_req : fetch_req;
    assign bus_rsp = '{done: done_q, rdata: rdata_q};

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            phase       <= ph_idle;
            done_q      <= 1'b0;
            read        <= 1'b0;
            write       <= 1'b0;
            sync        <= 1'b0;
            bus_status  <= bus_idle;
            address_out <= '1;
            data_out    <= '1;
        end
        else
        begin
            done_q <= 1'b0;
            case (phase)
                ph_idle:
                    // requester still holds valid while done is up
                    if (sel_req.valid && !done_q)
                    begin
                        address_out <= sel_req.addr;
                        bus_status  <= sel_req.write ? bus_mem_write : bus_mem_read;
                        sync        <= opcode_fetch;
                        if (sel_req.write)
                            data_out <= sel_req.wdata;
                        phase <= ph_addr;
                    end
                ph_addr:
                begin
                    read  <= (bus_status == bus_mem_read);
                    write <= (bus_status == bus_mem_write);
                    phase <= ph_strobe;
                end
                default:
                begin
                    read       <= 1'b0;
                    write      <= 1'b0;
                    sync       <= 1'b0;
                    bus_status <= bus_idle;
                    done_q     <= 1'b1;
                    phase      <= ph_idle;
                end
            endcase
        end
    end

    // sample on the edge that ends the strobe clock
    always_ff @(posedge clk)
    begin
        if (phase == ph_strobe)
            rdata_q <= data_in;
    end

    no_read_write_overlap: assert property (@(posedge clk) disable iff (reset)
        !(read && write));

endmodule

// ==== src/s1c88_core.sv ====
`timescale 1ns/1ps

module s1c88_core
#(
    parameter s1c88_bus_pkg::addr_t VECTOR_ADDR = '0
)
(
    input  logic                       clk,
    input  logic                       reset,
    input  s1c88_bus_pkg::data_t       data_in,
    output s1c88_bus_pkg::data_t       data_out,
    output s1c88_bus_pkg::addr_t       address_out,
    output s1c88_bus_pkg::bus_status_e bus_status,
    output logic                       read,
    output logic                       write,
    output logic                       sync
);
    import s1c88_bus_pkg::*;
    import s1c88_isa_pkg::*;

    bus_req_t fetch_req;
    bus_req_t exec_req;
    bus_rsp_t bus_rsp;
    logic     opcode_fetch;
    instr_t   instr;
    decode_t  entry;
    logic     start;
    logic     finished;

    s1c88_fetch #(.VECTOR_ADDR(VECTOR_ADDR)) fetch_inst
    (
        .clk, .reset, .bus_rsp, .fetch_req, .opcode_fetch,
        .instr, .start, .entry, .finished
    );

    s1c88_microseq microseq_inst
    (
        .clk, .reset, .start, .entry, .instr, .bus_rsp, .exec_req, .finished
    );

    s1c88_bus_unit bus_unit_inst
    (
        .clk, .reset, .fetch_req, .exec_req, .opcode_fetch, .bus_rsp,
        .data_in, .data_out, .address_out, .bus_status, .read, .write, .sync
    );

endmodule

// ==== testbench/s1c88_tb.sv ====
`timescale 1ns/1ps

module s1c88_tb;
    import s1c88_bus_pkg::*;
    import s1c88_isa_pkg::*;

    localparam int SEED        = 15055;
    localparam int NUM_INSTR   = 200;
    localparam int STALL_LIMIT = 200;

    // opcodes with no table entry and no extension byte
    localparam data_t UNDEF_OPS [8] = '{8'h00, 8'h12, 8'h3F, 8'h80, 8'h9A, 8'hC5, 8'hF1, 8'hFF};

    // one bus cycle as it should appear on the pins
    typedef struct packed
    {
        bus_status_e kind;
        addr_t       addr;
        data_t       data;
        logic        sync;
    } bus_txn_t;

    logic        clk;
    logic        reset;
    data_t       data_in;
    data_t       data_out;
    addr_t       address_out;
    bus_status_e bus_status;
    logic        read;
    logic        write;
    logic        sync;

    data_t      mem [addr_t];
    data_t      ref_data [addr_t];
    bus_txn_t   expected [$];
    code_addr_t gen_pc;
    data_t      ref_ep;
    data_t      ref_br;
    logic       prev_strobe;
    logic       prev_addr_phase;

    s1c88_core #(.VECTOR_ADDR(24'h000000)) uut
    (
        .clk, .reset, .data_in, .data_out, .address_out, .bus_status, .read, .write, .sync
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic data_t fill_byte(input addr_t a);
        return a[23:16] ^ {a[11:8], a[15:12]} ^ a[7:0] ^ 8'hA5;
    endfunction

    function automatic data_t read_mem(input addr_t a);
        return mem.exists(a) ? mem[a] : fill_byte(a);
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t want);
        if (got !== want)
            abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, want));
    endtask

    task automatic check_data(input string name, input data_t got, input data_t want);
        if (got !== want)
            abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, want));
    endtask

    task automatic check_status(input string name, input bus_status_e got,
                                input bus_status_e want);
        if (got !== want)
            abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, want));
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want)
            abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, want));
    endtask

    task automatic expect_txn(input bus_status_e kind, input addr_t a, input data_t d,
                              input logic s);
        expected.push_back('{kind, a, d, s});
    endtask

    // code byte goes into memory and becomes one expected fetch
    task automatic put_code(input data_t b, input logic is_opcode);
        mem[{8'h00, gen_pc}] = b;
        expect_txn(bus_mem_read, {8'h00, gen_pc}, b, is_opcode);
        gen_pc = gen_pc + 16'd1;
    endtask

    task automatic gen_ld_ep(input data_t n);
        put_code(8'hCE, 1'b1);
        put_code(8'hC5, 1'b0);
        put_code(n, 1'b0);
        ref_ep = n;
    endtask

    task automatic gen_instr();
        int unsigned pick;
        data_t       n;
        data_t       ll;
        addr_t       a;
        logic [2:0]  idx;
        pick = $urandom % 100;
        // small ll range so reads often hit earlier writes
        ll   = data_t'($urandom % 16);
        n    = data_t'($urandom);
        idx  = 3'($urandom);
        a    = {ref_ep, ref_br, ll};
        if (pick < 10)
            gen_ld_ep(data_t'(1 + $urandom % 255));
        else if (pick < 25)
        begin
            n = 8'h10 + data_t'($urandom % 4);
            put_code(8'hB4, 1'b1);
            put_code(n, 1'b0);
            ref_br = n;
        end
        else if (pick < 55)
        begin
            put_code(8'h44, 1'b1);
            put_code(ll, 1'b0);
            expect_txn(bus_mem_read, a, ref_data.exists(a) ? ref_data[a] : fill_byte(a), 1'b0);
        end
        else if (pick < 80)
        begin
            put_code(8'hDD, 1'b1);
            put_code(ll, 1'b0);
            put_code(n, 1'b0);
            expect_txn(bus_mem_write, a, n, 1'b0);
            ref_data[a] = n;
        end
        else
            put_code(UNDEF_OPS[idx], 1'b1);
    endtask

    task automatic build_program();
        code_addr_t vec;
        int         i;
        vec = code_addr_t'(32'h0100 + $urandom % 32'h7E01);
        mem[24'h000000] = vec[7:0];
        mem[24'h000001] = vec[15:8];
        expect_txn(bus_mem_read, 24'h000000, vec[7:0], 1'b0);
        expect_txn(bus_mem_read, 24'h000001, vec[15:8], 1'b0);
        gen_pc = vec;
        ref_ep = 8'h00;
        ref_br = 8'h00;
        gen_ld_ep(data_t'(1 + $urandom % 255));
        for (i = 1; i < NUM_INSTR; i++)
            gen_instr();
        // trailing nop whose fetch is the last checked cycle
        put_code(8'h00, 1'b1);
    endtask

    // memory model with read data following the address just after each edge
    initial
    begin
        data_in = '1;
        forever
        begin
            @(posedge clk);
            if (write)
                mem[address_out] = data_out;
            #1;
            data_in = read_mem(address_out);
        end
    end

    // bus monitor
    always @(posedge clk)
    begin
        bus_txn_t txn;
        if (!reset)
        begin
            if (read && write)
                abort_run("read and write strobes were high in the same clock");
            if (read || write)
            begin
                if (prev_strobe)
                    abort_run("a read or write strobe lasted more than one clock");
                if (expected.size() == 0)
                    abort_run("a bus cycle came after the last expected transaction");
                txn = expected.pop_front();
                check_status("bus_status", bus_status, txn.kind);
                check_flag("read", read, txn.kind == bus_mem_read);
                check_addr("address_out", address_out, txn.addr);
                check_flag("sync", sync, txn.sync);
                if (write)
                    check_data("data_out", data_out, txn.data);
                else
                    check_data("data_in", data_in, txn.data);
            end
            else
            begin
                if (prev_strobe)
                    check_status("bus_status", bus_status, bus_idle);
                if (prev_addr_phase)
                    abort_run("a bus cycle had no strobe in its second clock");
                if (bus_status == bus_idle)
                    check_flag("sync", sync, 1'b0);
                else if (expected.size() != 0)
                    check_flag("sync", sync, expected[0].sync);
            end
            prev_strobe     = read || write;
            prev_addr_phase = !(read || write) && (bus_status != bus_idle);
        end
    end

    initial
    begin
        int stall;
        int last_size;
        reset           = 1'b1;
        prev_strobe     = 1'b0;
        prev_addr_phase = 1'b0;
        void'($urandom(SEED));
        build_program();
        repeat (16) @(posedge clk);
        #1;
        reset     = 1'b0;
        stall     = 0;
        last_size = expected.size();
        while (expected.size() != 0)
        begin
            @(negedge clk);
            if (expected.size() != last_size)
            begin
                stall     = 0;
                last_size = expected.size();
            end
            else
                stall++;
            if (stall > STALL_LIMIT)
                abort_run($sformatf("timeout with %0d expected bus transactions never seen",
                                    expected.size()));
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
src/s1c88_bus_pkg.sv
src/s1c88_isa_pkg.sv
src/s1c88_decode.sv
src/s1c88_fetch.sv
src/s1c88_microseq.sv
src/s1c88_bus_unit.sv
src/s1c88_core.sv
testbench/s1c88_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= s1c88_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
